//--- Makefile
TOP := pid_loop_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f tb.f

obj_dir/V$(TOP): tb.f rtl/*.sv verification/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -qx "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- rtl/output_scaler.sv
`timescale 1ns/10ps

module output_scaler #(
	parameter int W_OUT		= 48,	// pid result width
	parameter int OUT_SHIFT	= 8,	// right shift before saturation
	parameter int W_DAC		= 16	// dac code width
) (
	input  logic					clk_in,
	input  logic					reset_in,

	input  logic signed [W_OUT-1:0]	data,		// pid output
	input  logic					data_valid,	// pid strobe

	output logic [W_DAC-1:0]		dac_data,	// offset binary code
	output logic					dac_valid	// pid strobe, one cycle later
);

	////////////////////////////////////////////////////////////////////////////
	// limits of the signed dac range, at accumulator width
	////////////////////////////////////////////////////////////////////////////

	localparam logic signed [W_OUT-1:0] DAC_MAX = {{(W_OUT-W_DAC+1){1'b0}}, {(W_DAC-1){1'b1}}};
	localparam logic signed [W_OUT-1:0] DAC_MIN = ~DAC_MAX;

	logic signed [W_OUT-1:0]	shifted;	// scaled result
	logic signed [W_DAC-1:0]	sat;		// clamped two's complement
	logic [W_DAC-1:0]			code;		// msb flipped

	assign shifted	= data >>> OUT_SHIFT;
	assign sat		= (shifted > DAC_MAX) ? DAC_MAX[W_DAC-1:0] :
					  (shifted < DAC_MIN) ? DAC_MIN[W_DAC-1:0] : shifted[W_DAC-1:0];
	assign code		= {~sat[W_DAC-1], sat[W_DAC-2:0]};	// zero maps to midscale

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			dac_valid	<= 1'b0;
			dac_data	<= {1'b1, {(W_DAC-1){1'b0}}};	// midscale
		end else begin
			dac_valid	<= data_valid;
			if (data_valid) begin
				dac_data	<= code;	// hold between updates
			end
		end
	end

endmodule

//--- rtl/oversample_filter.sv
`timescale 1ns/10ps

module oversample_filter #(
	parameter int W_ADC		= 16,	// sample width
	parameter int OS_LOG	= 2	// log2 of samples per block
) (
	input  logic					clk_in,
	input  logic					reset_in,

	input  logic signed [W_ADC-1:0]	adc_data,	// raw adc sample
	input  logic					adc_valid,	// sample strobe

	output logic signed [W_ADC-1:0]	filt_data,	// block mean
	output logic					filt_valid	// one cycle per block
);

	////////////////////////////////////////////////////////////////////////////
	// local widths
	////////////////////////////////////////////////////////////////////////////

	localparam int W_SUM = W_ADC + OS_LOG;	// room for 2^OS_LOG samples

	logic [OS_LOG-1:0]			cnt;		// samples taken in this block
	logic signed [W_SUM-1:0]	sum;		// running block sum
	logic signed [W_SUM-1:0]	sum_next;	// sum including current sample
	logic signed [W_SUM-1:0]	mean;		// floor of sum / 2^OS_LOG
	logic						last;		// current sample closes block

	////////////////////////////////////////////////////////////////////////////
	// combinational
	////////////////////////////////////////////////////////////////////////////

	assign sum_next	= sum + adc_data;			// adc sign extends to W_SUM
	assign mean		= sum_next >>> OS_LOG;		// arithmetic, rounds to -inf
	assign last		= &cnt;					// 2^OS_LOG-th sample

	////////////////////////////////////////////////////////////////////////////
	// sequential
	////////////////////////////////////////////////////////////////////////////

	// sample counter and accumulator
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			cnt	<= '0;
			sum	<= '0;
		end else if (adc_valid) begin
			cnt	<= cnt + 1'b1;			// wraps at block end
			sum	<= last ? '0 : sum_next;	// restart after block
		end
	end

	// output strobe, one cycle on block end
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			filt_valid	<= 1'b0;
		end else begin
			filt_valid	<= adc_valid && last;
		end
	end

	// mean register, loaded only on block end
	always_ff @(posedge clk_in) begin
		if (adc_valid && last) begin
			filt_data	<= mean[W_ADC-1:0];	// mean always fits W_ADC
		end
	end

endmodule

//--- rtl/pid_core.sv
`timescale 1ns/10ps

module pid_core #(
	parameter int W_IN			= 16,	// input sample width
	parameter int W_OUT			= 48,	// accumulator width
	parameter int COMP_LATENCY	= 1	// cycles spent in ST_COMPUTE
) (
	input  logic					clk_in,
	input  logic					reset_in,

	input  logic signed [W_IN-1:0]	data,			// filtered sample
	input  logic					data_valid,		// sample strobe

	input  pid_pkg::pid_params_t	staged,			// host staged parameters
	input  logic					update,			// load staged into active
	input  logic					clear,			// zero pid memory

	output logic signed [W_OUT-1:0]	data_out,		// pid output u
	output logic					data_valid_out	// high in ST_SEND
);

	////////////////////////////////////////////////////////////////////////////
	// local parameters
	////////////////////////////////////////////////////////////////////////////

	localparam int W_COEF	= pid_pkg::COEF_W;
	localparam int W_E		= ((W_IN > W_COEF) ? W_IN : W_COEF) + 1;	// error width
	localparam int W_K		= W_COEF + 2;		// k2 needs two extra bits
	localparam int W_CNT	= (COMP_LATENCY > 1) ? $clog2(COMP_LATENCY) : 1;

	localparam logic signed [W_OUT-1:0] MAX_OUTPUT = {1'b0, {(W_OUT-1){1'b1}}};
	localparam logic signed [W_OUT-1:0] MIN_OUTPUT = ~MAX_OUTPUT;

	pid_pkg::pid_state_e		state, state_next;
	logic [W_CNT-1:0]			cnt;		// intrastate counter

	logic signed [W_IN-1:0]		sample;		// latched input
	pid_pkg::pid_params_t		active;		// parameters set by update
	pid_pkg::pid_params_t		work;		// snapshot for the sample in flight

	logic signed [W_E-1:0]		e_cur;		// setpoint minus sample
	logic signed [W_E-1:0]		e_prev0;	// last error
	logic signed [W_E-1:0]		e_prev1;	// error before that
	logic signed [W_K-1:0]		k1, k2, k3;	// z-domain coefficients
	logic signed [W_OUT-1:0]	u_prev;		// last output
	logic signed [W_OUT-1:0]	delta_u;	// increment this step
	logic signed [W_OUT-1:0]	u_cur;		// unrailed sum
	logic						overflow;	// signed wrap of u_cur

	logic						accept;		// sample taken this edge

	////////////////////////////////////////////////////////////////////////////
	// datapath
	////////////////////////////////////////////////////////////////////////////

	assign accept	= data_valid && (state == pid_pkg::ST_IDLE);	// busy drops it

	assign e_cur	= work.setpoint - sample;

	assign k1		= work.p_coef + work.i_coef + work.d_coef;	// p+i+d
	assign k2		= -work.p_coef - (W_K'(work.d_coef) <<< 1);	// -p-2d
	assign k3		= work.d_coef;								// d

	assign delta_u	= k1 * e_cur + k2 * e_prev0 + k3 * e_prev1;	// all signed, W_OUT
	assign u_cur	= u_prev + delta_u;

	// both addends agree in sign but the sum does not
	assign overflow	= (delta_u[W_OUT-1] == u_prev[W_OUT-1]) &&
					  (u_cur[W_OUT-1] != u_prev[W_OUT-1]);

	assign data_out			= overflow ? (u_prev[W_OUT-1] ? MIN_OUTPUT : MAX_OUTPUT) : u_cur;
	assign data_valid_out	= (state == pid_pkg::ST_SEND);

	////////////////////////////////////////////////////////////////////////////
	// registers
	////////////////////////////////////////////////////////////////////////////

	// sample and parameter snapshot, active copy follows staged through reset
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			sample	<= '0;
			active	<= staged;		// pid_regs holds INIT values here
			work	<= staged;
		end else begin
			if (update) begin
				active	<= staged;		// in-flight sample keeps work copy
			end
			if (accept) begin
				sample	<= data;
				work	<= active;
			end
		end
	end

	// output and error history
	always_ff @(posedge clk_in) begin
		if (reset_in || clear) begin
			u_prev	<= '0;
			e_prev0	<= '0;
			e_prev1	<= '0;
		end else if (state == pid_pkg::ST_DONE) begin
			u_prev	<= data_out;	// railed value feeds back
			e_prev0	<= e_cur;
			e_prev1	<= e_prev0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// state machine
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			state	<= pid_pkg::ST_IDLE;
			cnt		<= '0;
		end else begin
			state	<= state_next;
			cnt		<= (state == pid_pkg::ST_COMPUTE && state_next == state) ? cnt + 1'b1 : '0;
		end
	end

	always_comb begin
		state_next = state;		// hold by default
		case (state)
			pid_pkg::ST_IDLE: begin
				if (data_valid) state_next = pid_pkg::ST_COMPUTE;
			end
			pid_pkg::ST_COMPUTE: begin
				if (cnt == W_CNT'(COMP_LATENCY - 1)) state_next = pid_pkg::ST_SEND;
			end
			pid_pkg::ST_SEND:	state_next = pid_pkg::ST_DONE;
			pid_pkg::ST_DONE:	state_next = pid_pkg::ST_IDLE;
			default:			state_next = pid_pkg::ST_IDLE;
		endcase
	end

endmodule

//--- rtl/pid_loop_top.sv
`timescale 1ns/10ps

module pid_loop_top #(
	parameter int W_ADC			= 16,	// adc sample width
	parameter int OS_LOG		= 2,	// 4 samples per block
	parameter int W_OUT			= 48,	// pid accumulator width
	parameter int COMP_LATENCY	= 1,	// compute cycles
	parameter int OUT_SHIFT		= 8,	// scaler right shift
	parameter int W_DAC			= 16	// dac width
) (
	input  logic					clk_in,
	input  logic					reset_in,

	input  logic signed [W_ADC-1:0]	adc_data,
	input  logic					adc_valid,

	input  pid_pkg::wb_req_t		wb_req,
	output pid_pkg::wb_rsp_t		wb_rsp,

	output logic [W_DAC-1:0]		dac_data,
	output logic					dac_valid
);

	// power up parameter set, loop idles at midscale until programmed
	localparam logic signed [pid_pkg::COEF_W-1:0] SETPOINT_INIT	= '0;
	localparam logic signed [pid_pkg::COEF_W-1:0] P_COEF_INIT	= '0;
	localparam logic signed [pid_pkg::COEF_W-1:0] I_COEF_INIT	= '0;
	localparam logic signed [pid_pkg::COEF_W-1:0] D_COEF_INIT	= '0;

	////////////////////////////////////////////////////////////////////////////
	// interconnect
	////////////////////////////////////////////////////////////////////////////

	logic signed [W_ADC-1:0]	filt_data;	// block mean
	logic						filt_valid;
	logic signed [W_OUT-1:0]	pid_data;	// wide pid output
	logic						pid_valid;
	pid_pkg::pid_params_t		staged;		// host side parameter set
	logic						update;		// control bit 0
	logic						clear;		// control bit 1

	oversample_filter #(.W_ADC(W_ADC), .OS_LOG(OS_LOG)) i_oversample_filter (
		.clk_in, .reset_in, .adc_data, .adc_valid, .filt_data, .filt_valid
	);

	pid_core #(.W_IN(W_ADC), .W_OUT(W_OUT), .COMP_LATENCY(COMP_LATENCY)) i_pid_core (
		.clk_in, .reset_in,
		.data(filt_data), .data_valid(filt_valid),
		.staged, .update, .clear,
		.data_out(pid_data), .data_valid_out(pid_valid)
	);

	pid_regs #(
		.SETPOINT_INIT(SETPOINT_INIT), .P_COEF_INIT(P_COEF_INIT),
		.I_COEF_INIT(I_COEF_INIT), .D_COEF_INIT(D_COEF_INIT)
	) i_pid_regs (
		.clk_in, .reset_in, .wb_req, .wb_rsp, .staged, .update, .clear
	);

	output_scaler #(.W_OUT(W_OUT), .OUT_SHIFT(OUT_SHIFT), .W_DAC(W_DAC)) i_output_scaler (
		.clk_in, .reset_in,
		.data(pid_data), .data_valid(pid_valid),
		.dac_data, .dac_valid
	);

endmodule

//--- rtl/pid_pkg.sv
package pid_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths fixed by the register map
	////////////////////////////////////////////////////////////////////////////

	localparam int COEF_W = 16;	// setpoint and coefficient width, signed

	// pid parameter set, staged in pid_regs and active in pid_core
	typedef struct packed {
		logic signed [COEF_W-1:0]	setpoint;	// lock setpoint
		logic signed [COEF_W-1:0]	p_coef;		// proportional
		logic signed [COEF_W-1:0]	i_coef;		// integral
		logic signed [COEF_W-1:0]	d_coef;		// derivative
	} pid_params_t;

	////////////////////////////////////////////////////////////////////////////
	// wishbone classic, host side and slave side
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic			cyc;	// bus cycle in progress
		logic			stb;	// strobe, valid transfer
		logic			we;	// write enable
		logic [3:0]		adr;	// word address
		logic [31:0]	dat;	// write data
	} wb_req_t;

	typedef struct packed {
		logic			ack;	// single cycle acknowledge
		logic [31:0]	dat;	// read data, valid with ack
	} wb_rsp_t;

	// register map, word addresses
	typedef enum logic [3:0] {
		REG_SETPOINT	= 4'd0,
		REG_P_COEF		= 4'd1,
		REG_I_COEF		= 4'd2,
		REG_D_COEF		= 4'd3,
		REG_CONTROL		= 4'd4	// bit 0 update, bit 1 clear
	} reg_addr_e;

	// pid core sequencing
	typedef enum logic [1:0] {
		ST_IDLE		= 2'd0,	// wait for filtered sample
		ST_COMPUTE	= 2'd1,	// arithmetic settles
		ST_SEND		= 2'd2,	// output valid downstream
		ST_DONE		= 2'd3	// latch output and error history
	} pid_state_e;

endpackage

//--- rtl/pid_regs.sv
`timescale 1ns/10ps

module pid_regs #(
	parameter logic signed [pid_pkg::COEF_W-1:0] SETPOINT_INIT	= '0,	// staged at reset
	parameter logic signed [pid_pkg::COEF_W-1:0] P_COEF_INIT	= '0,
	parameter logic signed [pid_pkg::COEF_W-1:0] I_COEF_INIT	= '0,
	parameter logic signed [pid_pkg::COEF_W-1:0] D_COEF_INIT	= '0
) (
	input  logic					clk_in,
	input  logic					reset_in,

	input  pid_pkg::wb_req_t		wb_req,		// host request
	output pid_pkg::wb_rsp_t		wb_rsp,		// ack and read data

	output pid_pkg::pid_params_t	staged,		// to pid_core
	output logic					update,		// one cycle, with ack
	output logic					clear		// one cycle, with ack
);

	////////////////////////////////////////////////////////////////////////////
	// bus decode
	////////////////////////////////////////////////////////////////////////////

	localparam int W_COEF = pid_pkg::COEF_W;

	pid_pkg::reg_addr_e	adr;		// decoded word address
	logic				take;		// accept request this edge
	logic				wr;			// accepted write
	logic [31:0]		rdat;		// read mux output

	assign adr	= pid_pkg::reg_addr_e'(wb_req.adr);
	assign take	= wb_req.cyc && wb_req.stb && !wb_rsp.ack;	// no back to back ack
	assign wr	= take && wb_req.we;

	// staged regs read back sign extended, control and holes read zero
	always_comb begin
		case (adr)
			pid_pkg::REG_SETPOINT:	rdat = {{(32-W_COEF){staged.setpoint[W_COEF-1]}}, staged.setpoint};
			pid_pkg::REG_P_COEF:	rdat = {{(32-W_COEF){staged.p_coef[W_COEF-1]}}, staged.p_coef};
			pid_pkg::REG_I_COEF:	rdat = {{(32-W_COEF){staged.i_coef[W_COEF-1]}}, staged.i_coef};
			pid_pkg::REG_D_COEF:	rdat = {{(32-W_COEF){staged.d_coef[W_COEF-1]}}, staged.d_coef};
			default:				rdat = '0;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// handshake and pulses
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			wb_rsp.ack	<= 1'b0;
			update		<= 1'b0;
			clear		<= 1'b0;
		end else begin
			wb_rsp.ack	<= take;		// exactly one cycle
			update		<= wr && (adr == pid_pkg::REG_CONTROL) && wb_req.dat[0];
			clear		<= wr && (adr == pid_pkg::REG_CONTROL) && wb_req.dat[1];
		end
	end

	// read data, valid while ack high
	always_ff @(posedge clk_in) begin
		if (take) begin
			wb_rsp.dat	<= wb_req.we ? 32'd0 : rdat;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// staged parameter registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			staged.setpoint	<= SETPOINT_INIT;
			staged.p_coef	<= P_COEF_INIT;
			staged.i_coef	<= I_COEF_INIT;
			staged.d_coef	<= D_COEF_INIT;
		end else if (wr) begin
			case (adr)
				pid_pkg::REG_SETPOINT:	staged.setpoint	<= wb_req.dat[W_COEF-1:0];
				pid_pkg::REG_P_COEF:	staged.p_coef	<= wb_req.dat[W_COEF-1:0];
				pid_pkg::REG_I_COEF:	staged.i_coef	<= wb_req.dat[W_COEF-1:0];
				pid_pkg::REG_D_COEF:	staged.d_coef	<= wb_req.dat[W_COEF-1:0];
				default: ;	// control and holes leave staging alone
			endcase
		end
	end

endmodule

//--- tb.f
rtl/pid_pkg.sv
rtl/oversample_filter.sv
rtl/pid_core.sv
rtl/pid_regs.sv
rtl/output_scaler.sv
rtl/pid_loop_top.sv
verification/pid_loop_chk.sv
verification/pid_loop_tb.sv

//--- verification/pid_loop_chk.sv
`timescale 1ns/10ps

module pid_loop_chk (
	input  logic				clk_in,
	input  logic				reset_in,
	input  pid_pkg::wb_req_t	wb_req,
	input  pid_pkg::wb_rsp_t	wb_rsp,
	input  logic				dac_valid
);

	int unsigned fail_count = 0;	// failed assertions so far

	////////////////////////////////////////////////////////////////////////////
	// wishbone handshake
	////////////////////////////////////////////////////////////////////////////

	ack_single: assert property (@(posedge clk_in) disable iff (reset_in)
		wb_rsp.ack |=> !wb_rsp.ack)
		else begin
			$error("wishbone ack high on two consecutive cycles");
			fail_count++;
		end

	ack_after_req: assert property (@(posedge clk_in) disable iff (reset_in)
		wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
		else begin
			$error("wishbone ack without a preceding request");
			fail_count++;
		end

	////////////////////////////////////////////////////////////////////////////
	// output strobes
	////////////////////////////////////////////////////////////////////////////

	dac_pulse: assert property (@(posedge clk_in) disable iff (reset_in)
		dac_valid |=> !dac_valid)
		else begin
			$error("dac_valid high on two consecutive cycles");
			fail_count++;
		end

	quiet_after_reset: assert property (@(posedge clk_in)
		reset_in |=> (!dac_valid && !wb_rsp.ack))
		else begin
			$error("dac_valid or ack high right after reset");
			fail_count++;
		end

endmodule

bind pid_loop_top pid_loop_chk i_pid_loop_chk (
	.clk_in, .reset_in, .wb_req, .wb_rsp, .dac_valid
);

//--- verification/pid_loop_tb.sv
`timescale 1ns/10ps

module pid_loop_tb;

	localparam int		BLOCK		= 4;						// 2^OS_LOG samples per mean
	localparam longint	SCALE		= 256;						// 2^OUT_SHIFT
	localparam longint	U_MAX		= (longint'(1) <<< 47) - 1;	// 48 bit rails
	localparam longint	U_MIN		= -(longint'(1) <<< 47);
	localparam int		RAIL_BLOCKS	= 65600;					// rail hit near step 65540
	localparam int		N_BLOCKS	= 4 + 6 + 30 + 40 + 6 + RAIL_BLOCKS;
	localparam int		N_BUS		= 60;						// bus cycles, rounded up
	localparam int		LIMIT		= N_BLOCKS * 20 + N_BUS * 10 + 1000;

	logic					clk_in;
	logic					reset_in;
	logic signed [15:0]		adc_data;
	logic					adc_valid;
	pid_pkg::wb_req_t		wb_req;
	pid_pkg::wb_rsp_t		wb_rsp;
	logic [15:0]			dac_data;
	logic					dac_valid;

	logic [15:0]	exp_q[$];			// dac words in flight
	longint			stg[4];				// staged setpoint, p, i, d
	longint			act[4];				// active copy
	longint			m_u, m_e0, m_e1;	// model history
	logic [15:0]	expected;

	pid_loop_top i_pid_loop_top (
		.clk_in, .reset_in, .adc_data, .adc_valid, .wb_req, .wb_rsp, .dac_data, .dac_valid
	);

	initial begin
		clk_in = 1'b0;
		forever #5 clk_in = ~clk_in;	// 100 MHz
	end

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic longint floor_div(input longint a, input longint b);
		longint q;
		q = a / b;					// truncates toward zero
		if ((a % b != 0) && ((a < 0) != (b < 0))) begin
			q = q - 1;
		end
		return q;
	endfunction

	// one loop step from the sum of a block, returns the dac code
	function automatic logic [15:0] model_step(input longint sum);
		longint e, k1, k2, k3, u, s;
		e	= act[0] - floor_div(sum, BLOCK);
		k1	= act[1] + act[2] + act[3];
		k2	= -act[1] - 2 * act[3];
		k3	= act[3];
		u	= m_u + k1 * e + k2 * m_e0 + k3 * m_e1;
		if (u > U_MAX || u < U_MIN) begin
			u = (m_u < 0) ? U_MIN : U_MAX;	// rail toward previous output
		end
		m_e1	= m_e0;
		m_e0	= e;
		m_u		= u;
		s		= floor_div(u, SCALE);
		s		= (s > 32767) ? 32767 : ((s < -32768) ? -32768 : s);
		return 16'(s + 32768);					// offset binary
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// failure and bus tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic mismatch_stop(input string sig, input logic [31:0] exp_v,
			input logic [31:0] act_v);
		$display("CHECK FAILED: %s expected %h actual %h", sig, exp_v, act_v);
		$display("SOME TESTS FAILED");
		$fatal(1, "value mismatch");
	endtask

	task automatic drain_outputs();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < 200) begin
			@(posedge clk_in);
			n++;
		end
		if (exp_q.size() != 0) begin
			abort_run("expected DAC words never came out of the loop");
		end
	endtask

	task automatic bus_transfer(input logic we, input logic [3:0] adr, input logic [31:0] dat,
			output logic [31:0] rdat);
		int n;
		@(posedge clk_in);
		wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
		n = 0;
		do begin
			@(posedge clk_in);
			n++;
		end while (!wb_rsp.ack && n < 16);
		if (!wb_rsp.ack) begin
			abort_run("register block never acknowledged the bus cycle");
		end
		rdat = wb_rsp.dat;				// valid while ack high
		wb_req <= '0;
	endtask

	// write plus model bookkeeping, control waits for an idle loop
	task automatic wb_write(input logic [3:0] adr, input logic [31:0] dat);
		logic [31:0] unused;
		if (adr == 4'd4) begin
			drain_outputs();
		end
		bus_transfer(1'b1, adr, dat, unused);
		if (adr < 4'd4) begin
			stg[adr] = longint'($signed(dat[15:0]));
		end else if (adr == 4'd4) begin
			if (dat[0]) begin
				act = stg;					// update
			end
			if (dat[1]) begin
				m_u		= 0;				// clear
				m_e0	= 0;
				m_e1	= 0;
			end
		end
	endtask

	task automatic wb_read(input logic [3:0] adr, output logic [31:0] rdat);
		bus_transfer(1'b0, adr, 32'd0, rdat);
	endtask

	task automatic program_params(input logic [31:0] sp, input logic [31:0] p,
			input logic [31:0] i, input logic [31:0] d);
		wb_write(4'd0, sp);
		wb_write(4'd1, p);
		wb_write(4'd2, i);
		wb_write(4'd3, d);
	endtask

	// one block of samples with random idle gaps, expected word queued
	task automatic send_block(input int max_gap, input bit fixed, input logic signed [15:0] lvl);
		logic signed [15:0]	s;
		longint				sum;
		int					gap;
		sum = 0;
		for (int k = 0; k < BLOCK; k++) begin
			gap = (max_gap > 0) ? $urandom_range(max_gap, 0) : 0;
			repeat (gap) begin
				@(posedge clk_in);
				adc_valid <= 1'b0;
			end
			s = fixed ? lvl : 16'($urandom);
			@(posedge clk_in);
			adc_valid	<= 1'b1;
			adc_data	<= s;
			sum += s;
		end
		@(posedge clk_in);
		adc_valid <= 1'b0;
		exp_q.push_back(model_step(sum));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// compare and watchdog
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clk_in) begin
		if (!reset_in && dac_valid) begin
			if (exp_q.size() == 0) begin
				abort_run("dac_valid pulsed with no block outstanding");
			end else begin
				expected = exp_q.pop_front();
				assert (dac_data === expected)
					else mismatch_stop("dac_data", 32'(expected), 32'(dac_data));
			end
		end
	end

	// protocol watch from the bound checker
	always @(posedge clk_in) begin
		if (i_pid_loop_top.i_pid_loop_chk.fail_count != 0) begin
			abort_run("a protocol assertion in the bound checker failed");
		end
	end

	initial begin
		repeat (LIMIT) @(posedge clk_in);
		abort_run("watchdog expired before the tests finished");
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int				a;
		int				p;
		logic [31:0]	v;
		logic [31:0]	rd;
		void'($urandom(49022));
		reset_in	= 1'b1;
		adc_valid	= 1'b0;
		adc_data	= '0;
		wb_req		= '0;
		stg			= '{0, 0, 0, 0};
		act			= '{0, 0, 0, 0};
		m_u			= 0;
		m_e0		= 0;
		m_e1		= 0;
		repeat (10) @(posedge clk_in);
		reset_in <= 1'b0;
		repeat (2) @(posedge clk_in);

		// readback, sign extended, holes read zero
		for (a = 0; a < 4; a++) begin
			v = $urandom;
			wb_write(4'(a), v);
			wb_read(4'(a), rd);
			assert (rd === {{16{v[15]}}, v[15:0]})
				else mismatch_stop("wb_rsp.dat", {{16{v[15]}}, v[15:0]}, rd);
		end
		for (a = 5; a < 16; a++) begin
			wb_write(4'(a), $urandom);
		end
		for (a = 0; a < 16; a++) begin
			wb_read(4'(a), rd);
			v = (a < 4) ? 32'(stg[a]) : 32'd0;
			assert (rd === v) else mismatch_stop("wb_rsp.dat", v, rd);
		end

		// staging alone keeps midscale, update applies it
		program_params($urandom, $urandom, $urandom, $urandom);
		repeat (4) send_block(3, 1'b0, '0);
		wb_write(4'd4, 32'd1);
		repeat (6) send_block(3, 1'b0, '0);

		// proportional only, small gain keeps the dac in range
		p = $urandom_range(127, 1);
		if ($urandom_range(1, 0) == 1) begin
			p = -p;
		end
		program_params($urandom, 32'(p), 32'd0, 32'd0);
		wb_write(4'd4, 32'd3);
		repeat (30) send_block(3, 1'b0, '0);

		// full pid
		program_params($urandom, $urandom, $urandom, $urandom);
		wb_write(4'd4, 32'd1);
		repeat (40) send_block(3, 1'b0, '0);

		// clear restarts the history
		wb_write(4'd4, 32'd2);
		repeat (6) send_block(3, 1'b0, '0);

		// constant max error integrates into the rail
		program_params(32'h7fff, 32'd0, 32'h7fff, 32'd0);
		wb_write(4'd4, 32'd3);
		repeat (RAIL_BLOCKS) send_block(0, 1'b1, -16'sd32768);
		drain_outputs();

		repeat (5) @(posedge clk_in);
		if (exp_q.size() == 0 && i_pid_loop_top.i_pid_loop_chk.fail_count == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			$display("SOME TESTS FAILED");
			$fatal(1, "protocol assertions failed during the run");
		end
	end

endmodule
